/* bench/t07_mmio_patterns.txt */
# columns: test name, operation, address (decimal), write data (hex), expected read data (hex)
# load writes the register bank at index address, stall is a read hit by a stray request
load_idx1      load   1     a1a1a1a1  00000000
load_idx0      load   0     5a5a0000  00000000
load_idx8      load   8     08080808  00000000
load_idx31     load   31    3131ffff  00000000
reg_rd_1025    read   1025  00000000  a1a1a1a1
reg_rd_1032    read   1032  00000000  08080808
reg_rd_1055    read   1055  00000000  3131ffff
reg_rd_1056    read   1056  00000000  5a5a0000
reg_rd_1040    read   1040  00000000  00000000
load_idx8_new  load   8     80808080  00000000
reg_rd_1032b   read   1032  00000000  80808080
mem_wr_1060    write  1060  12345678  00000000
mem_rd_1060    read   1060  00000000  12345678
mem_wr_1057    write  1057  0badf00d  00000000
mem_rd_1057    read   1057  00000000  0badf00d
mem_wr_1792    write  1792  deadbeef  00000000
mem_rd_1792    read   1792  00000000  deadbeef
fetch_36       fetch  36    00000000  12345678
fetch_32       fetch  32    00000000  0badf00d
fetch_768      fetch  768   00000000  deadbeef
mem_wr_1060b   write  1060  a5a5c3c3  00000000
fetch_36b      fetch  36    00000000  a5a5c3c3
tft_wr_1793    write  1793  7f7f0001  00000000
tft_wr_2047    write  2047  7f7f0002  00000000
tft_wr_1900    write  1900  00ff00ff  00000000
unm_wr_1030    write  1030  11111111  00000000
unm_rd_1900    read   1900  00000000  00000000
unm_wr_4096    write  4096  22222222  00000000
unm_rd_4096    read   4096  00000000  00000000
stall_rd_1060  stall  1060  00000000  a5a5c3c3
mem_rd_1060c   read   1060  00000000  a5a5c3c3
stall_rd_1025  stall  1025  00000000  a1a1a1a1
stall_rd_1792  stall  1792  00000000  deadbeef
fetch_768b     fetch  768   00000000  deadbeef

/* build.f */
hw/t07_pkg.sv
hw/t07_mem_handler.sv
hw/t07_mmio.sv
hw/t07_ext_mem.sv
hw/t07_ext_regs.sv
hw/t07_mmio_top.sv
bench/t07_mmio_assertions.sv
bench/t07_mmio_tb.sv

/* bench/t07_mmio_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module t07_mmio_tb
    import t07_pkg::*;
();

    localparam int TIMEOUT = 200;   // cycles any single wait may take

    logic      clk;
    logic      arst_n;
    logic      cpu_req;
    rwi_t      cpu_rwi;
    addr_t     cpu_addr;
    word_t     cpu_wdata;
    logic      cpu_ready;
    logic      cpu_done;
    logic      cpu_unmapped;
    logic      cpu_instr_fetch;
    word_t     cpu_rdata;
    logic      tft_wi;
    addr_t     tft_addr;
    word_t     tft_wdata;
    logic      tft_ack;
    logic      reg_wr_en;
    reg_addr_t reg_wr_addr;
    word_t     reg_wr_data;

    // tft model
    integer    seed = 32'h9b9b0264;
    logic      tft_active;          // strobe seen, ack pending
    int        tft_wait;            // cycles left before ack
    int        tft_strobes;
    int        tft_acks;
    addr_t     tft_seen_addr;
    word_t     tft_seen_data;

    int        tests;
    int        failed_tests;
    int        errors;
    int        test_errors;         // errors of the running test
    logic      timed_out;

    t07_mmio_top uut (
        .clk             (clk),
        .arst_n          (arst_n),
        .cpu_req         (cpu_req),
        .cpu_rwi         (cpu_rwi),
        .cpu_addr        (cpu_addr),
        .cpu_wdata       (cpu_wdata),
        .cpu_ready       (cpu_ready),
        .cpu_done        (cpu_done),
        .cpu_unmapped    (cpu_unmapped),
        .cpu_instr_fetch (cpu_instr_fetch),
        .cpu_rdata       (cpu_rdata),
        .tft_wi          (tft_wi),
        .tft_addr        (tft_addr),
        .tft_wdata       (tft_wdata),
        .tft_ack         (tft_ack),
        .reg_wr_en       (reg_wr_en),
        .reg_wr_addr     (reg_wr_addr),
        .reg_wr_data     (reg_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    // tft controller, acks each strobe after a random delay
    always @(posedge clk) begin
        if (tft_ack) begin
            tft_ack    <= 1'b0;         // one-cycle ack
            tft_active <= 1'b0;
        end else if (tft_wi) begin
            if (!tft_active) begin
                tft_active    <= 1'b1;
                tft_strobes   <= tft_strobes + 1;
                tft_seen_addr <= tft_addr;
                tft_seen_data <= tft_wdata;
                tft_wait      <= $unsigned($random(seed)) % 5;
            end else if (tft_wait == 0) begin
                tft_ack  <= 1'b1;
                tft_acks <= tft_acks + 1;
            end else begin
                tft_wait <= tft_wait - 1;
            end
        end
    end

    task automatic check_word(input string test, input string what,
                              input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED %s: %s expected %h actual %h", test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string test, input string what,
                              input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("FAILED %s: %s expected %0d actual %0d", test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string test, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: %s expected %b actual %b", test, what, exp, act);
            test_errors++;
        end
    endtask

    // map rules: reg region read only, tft window write only, nothing from 2048 up
    function automatic logic unmapped_by_map(input string op, input addr_t addr);
        if (addr <= INSTR_TOP) return 1'b0;     // always a fetch
        if (addr <= REG_TOP)   return (op == "write");
        if (addr <= DATA_TOP)  return 1'b0;
        if (addr < TFT_TOP)    return (op != "write");
        return 1'b1;
    endfunction

    task automatic wait_ready(input string test);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!cpu_ready && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!cpu_ready) begin
            $display("%s: cpu_ready stayed low for %0d cycles", test, TIMEOUT);
            timed_out = 1'b1;
            test_errors++;
        end
    endtask

    task automatic wait_done(input string test);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!cpu_done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!cpu_done) begin
            $display("%s: cpu_done did not arrive within %0d cycles", test, TIMEOUT);
            timed_out = 1'b1;
            test_errors++;
        end
    endtask

    task automatic load_register(input reg_addr_t index, input word_t value);
        @(posedge clk);
        reg_wr_en   <= 1'b1;
        reg_wr_addr <= index;
        reg_wr_data <= value;
        @(posedge clk);
        reg_wr_en   <= 1'b0;
    endtask

    task automatic run_access(input string test, input string op, input addr_t addr,
                              input word_t data, input word_t exp_data);
        logic exp_tft;
        int   strobes0;
        int   acks0;
        int   extra;
        exp_tft = (op == "write") && (addr > DATA_TOP) && (addr < TFT_TOP);
        wait_ready(test);
        if (timed_out) return;
        strobes0 = tft_strobes;
        acks0    = tft_acks;
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_rwi   <= (op == "write") ? RWI_WRITE : RWI_READ;
        cpu_addr  <= addr;
        cpu_wdata <= data;
        @(posedge clk);
        if (op == "stall") begin
            cpu_req   <= 1'b1;              // stray store while busy
            cpu_rwi   <= RWI_WRITE;
            cpu_wdata <= 32'hffff_ffff;
            @(negedge clk);
            check_flag(test, "cpu_ready during access", 1'b0, cpu_ready);
            @(posedge clk);
        end
        cpu_req <= 1'b0;
        wait_done(test);
        if (timed_out) return;
        check_word(test, "cpu_rdata", exp_data, cpu_rdata);
        check_flag(test, "cpu_unmapped", unmapped_by_map(op, addr), cpu_unmapped);
        check_flag(test, "cpu_instr_fetch", addr <= INSTR_TOP, cpu_instr_fetch);
        if (exp_tft) begin
            check_flag(test, "one tft strobe", 1'b1, tft_strobes == strobes0 + 1);
            check_flag(test, "tft_ack before cpu_done", 1'b1, tft_acks == acks0 + 1);
            check_addr(test, "tft_addr", addr, tft_seen_addr);
            check_word(test, "tft_wdata", data, tft_seen_data);
        end else begin
            check_flag(test, "tft strobe", 1'b0, tft_strobes != strobes0);
        end
        if (op == "stall") begin
            extra = 0;
            repeat (8) begin
                @(negedge clk);
                if (cpu_done) extra++;
            end
            check_flag(test, "single cpu_done", 1'b1, extra == 0);
        end
    endtask

    initial begin
        int    fd;
        string line;
        string name;
        string op;
        addr_t addr;
        word_t data;
        word_t exp_data;

        arst_n       = 1'b0;
        cpu_req      = 1'b0;
        cpu_rwi      = RWI_IDLE;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        tft_ack      = 1'b0;
        reg_wr_en    = 1'b0;
        reg_wr_addr  = '0;
        reg_wr_data  = '0;
        tft_active   = 1'b0;
        tft_wait     = 0;
        tft_strobes  = 0;
        tft_acks     = 0;
        tests        = 0;
        failed_tests = 0;
        errors       = 0;
        timed_out    = 1'b0;

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        test_errors = 0;                // idle levels straight out of reset
        @(negedge clk);
        check_flag("reset", "cpu_ready", 1'b1, cpu_ready);
        check_flag("reset", "cpu_done", 1'b0, cpu_done);
        check_flag("reset", "tft_wi", 1'b0, tft_wi);
        tests++;
        $display("%s reset", (test_errors == 0) ? "pass" : "fail");
        failed_tests += (test_errors != 0);
        errors += test_errors;

        fd = $fopen("bench/t07_mmio_patterns.txt", "r");
        if (fd == 0) begin
            $display("pattern file bench/t07_mmio_patterns.txt could not be opened");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == "#") continue;
                if ($sscanf(line, "%s %s %d %h %h", name, op, addr, data, exp_data) != 5) begin
                    continue;
                end
                test_errors = 0;
                if (op == "load") begin
                    load_register(addr[4:0], data);
                end else if (op == "read" || op == "write" || op == "fetch" || op == "stall") begin
                    run_access(name, op, addr, data, exp_data);
                end else begin
                    $display("%s: unknown operation %s in pattern file", name, op);
                    test_errors++;
                end
                tests++;
                if (test_errors == 0) begin
                    $display("pass %s", name);
                end else begin
                    $display("fail %s (%0d errors)", name, test_errors);
                    failed_tests++;
                end
                errors += test_errors;
            end
            $fclose(fd);
        end

        repeat (2) @(posedge clk);
        errors += uut.u_assertions.fail_count;
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests, failed_tests, errors, uut.u_assertions.fail_count);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/t07_mmio_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module t07_mmio_assertions
    import t07_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  cpu_ready,
    input  logic  cpu_done,
    input  rwi_t  hold_rwi,
    input  addr_t hold_addr,
    input  word_t hold_wdata,
    input  rwi_t  mem_rwi,
    input  logic  reg_ri,
    input  logic  tft_wi
);

    int unsigned fail_count = 0;    // read by the testbench at the end

    logic in_hold;                  // handler is neither idle nor done
    logic mem_sel;                  // memory has a command

    assign in_hold = !cpu_ready && !cpu_done;
    assign mem_sel = (mem_rwi != RWI_IDLE);

    one_target: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({mem_sel, reg_ri, tft_wi}))
        else begin
            fail_count++;
            $error("more than one target strobe high");
        end

    done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_done |=> !cpu_done)
        else begin
            fail_count++;
            $error("cpu_done longer than one cycle");
        end

    hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        in_hold ##1 in_hold |-> $stable(hold_rwi) && $stable(hold_addr) && $stable(hold_wdata))
        else begin
            fail_count++;
            $error("held request changed during HOLD");
        end

endmodule

// top level sees both the decoder strobes and the handler's held request
bind t07_mmio_top t07_mmio_assertions u_assertions (
    .clk        (clk),
    .arst_n     (arst_n),
    .cpu_ready  (cpu_ready),
    .cpu_done   (cpu_done),
    .hold_rwi   (hold_rwi),
    .hold_addr  (hold_addr),
    .hold_wdata (hold_wdata),
    .mem_rwi    (mem_rwi),
    .reg_ri     (reg_ri),
    .tft_wi     (tft_wi)
);

`default_nettype wire

/* hw/t07_mmio_top.sv */
`timescale 1ns/1ns
`default_nettype none

module t07_mmio_top
    import t07_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,

    // cpu port
    input  logic      cpu_req,
    input  rwi_t      cpu_rwi,
    input  addr_t     cpu_addr,
    input  word_t     cpu_wdata,
    output logic      cpu_ready,
    output logic      cpu_done,
    output logic      cpu_unmapped,
    output logic      cpu_instr_fetch,
    output word_t     cpu_rdata,

    // tft controller sits outside
    output logic      tft_wi,
    output addr_t     tft_addr,
    output word_t     tft_wdata,
    input  logic      tft_ack,

    // register bank load port
    input  logic      reg_wr_en,
    input  reg_addr_t reg_wr_addr,
    input  word_t     reg_wr_data
);

    // handler <-> decoder
    rwi_t      hold_rwi;
    addr_t     hold_addr;
    word_t     hold_wdata;
    logic      busy;
    logic      unmapped;
    word_t     ext_rdata;

    // decoder <-> memory
    rwi_t      mem_rwi;
    addr_t     mem_addr;
    word_t     mem_wdata;
    logic      mem_busy;
    word_t     mem_rdata;

    // decoder <-> register bank
    logic      reg_ri;
    reg_addr_t reg_addr;
    logic      reg_ack;
    word_t     reg_rdata;

    t07_mem_handler u_handler (
        .clk             (clk),
        .arst_n          (arst_n),
        .cpu_req         (cpu_req),
        .cpu_rwi         (cpu_rwi),
        .cpu_addr        (cpu_addr),
        .cpu_wdata       (cpu_wdata),
        .cpu_ready       (cpu_ready),
        .cpu_done        (cpu_done),
        .cpu_unmapped    (cpu_unmapped),
        .cpu_instr_fetch (cpu_instr_fetch),
        .cpu_rdata       (cpu_rdata),
        .busy            (busy),
        .ext_rdata       (ext_rdata),
        .unmapped        (unmapped),
        .hold_rwi        (hold_rwi),
        .hold_addr       (hold_addr),
        .hold_wdata      (hold_wdata)
    );

    t07_mmio u_mmio (
        .hold_rwi   (hold_rwi),
        .hold_addr  (hold_addr),
        .hold_wdata (hold_wdata),
        .busy       (busy),
        .unmapped   (unmapped),
        .ext_rdata  (ext_rdata),
        .mem_busy   (mem_busy),
        .mem_rdata  (mem_rdata),
        .mem_rwi    (mem_rwi),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .reg_ack    (reg_ack),
        .reg_rdata  (reg_rdata),
        .reg_ri     (reg_ri),
        .reg_addr   (reg_addr),
        .tft_ack    (tft_ack),
        .tft_wi     (tft_wi),
        .tft_addr   (tft_addr),
        .tft_wdata  (tft_wdata)
    );

    t07_ext_mem u_ext_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_rwi   (mem_rwi),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_busy  (mem_busy),
        .mem_rdata (mem_rdata)
    );

    t07_ext_regs u_ext_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .reg_ri      (reg_ri),
        .reg_addr    (reg_addr),
        .reg_ack     (reg_ack),
        .reg_rdata   (reg_rdata),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data)
    );

endmodule

`default_nettype wire

/* hw/t07_ext_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module t07_ext_regs
    import t07_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,

    // cpu read side, through the decoder
    input  logic      reg_ri,       // read strobe, held until acknowledged
    input  reg_addr_t reg_addr,
    output logic      reg_ack,      // one cycle after reg_ri rises
    output word_t     reg_rdata,    // valid with reg_ack

    // load port from outside
    input  logic      reg_wr_en,
    input  reg_addr_t reg_wr_addr,
    input  word_t     reg_wr_data
);

    localparam int NUM_REGS = 2 ** $bits(reg_addr_t);

    word_t regs [NUM_REGS];

    // bank, cleared on reset, written in one cycle from the load port
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr_en) begin
            regs[reg_wr_addr] <= reg_wr_data;
        end
    end

    // acknowledge follows the read strobe by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_ack <= 1'b0;
        end else begin
            reg_ack <= reg_ri;              // falls again once reg_ri is gone
        end
    end

    // read data captured on the first strobe cycle
    always_ff @(posedge clk) begin
        if (reg_ri && !reg_ack) begin
            reg_rdata <= regs[reg_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/t07_ext_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module t07_ext_mem
    import t07_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  rwi_t  mem_rwi,      // held steady by the decoder for the whole access
    input  addr_t mem_addr,     // tagged address, word index in bits 9:2
    input  word_t mem_wdata,
    output logic  mem_busy,     // high for MEM_WAIT cycles from the first command cycle
    output word_t mem_rdata     // valid in the cycle busy falls
);

    localparam int DEPTH = 2 ** $bits(mem_index_t);

    word_t      mem [DEPTH];    // instruction and data words share this array
    wait_cnt_t  wait_cnt;       // cycles spent on the current command
    mem_index_t index;
    logic       cmd_active;     // a command is presented
    logic       last_wait;      // final busy cycle, access happens at its end

    assign index      = mem_addr[9:2];
    assign cmd_active = (mem_rwi != RWI_IDLE);
    assign mem_busy   = cmd_active && (wait_cnt < wait_cnt_t'(MEM_WAIT));
    assign last_wait  = cmd_active && (wait_cnt == wait_cnt_t'(MEM_WAIT - 1));

    // wait counter
    // saturates at MEM_WAIT and stays there until the command goes idle,
    // so a held command is served only once
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (!cmd_active) begin
            wait_cnt <= '0;                     // restart only after idle
        end else if (mem_busy) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (last_wait) begin
            if (mem_rwi == RWI_WRITE) begin
                mem[index] <= mem_wdata;        // stored as busy falls
            end else begin
                mem_rdata <= mem[index];        // shown as busy falls
            end
        end
    end

endmodule

`default_nettype wire

/* hw/t07_mmio.sv */
`timescale 1ns/1ns
`default_nettype none

module t07_mmio
    import t07_pkg::*;
(
    // held request from the handler
    input  rwi_t      hold_rwi,
    input  addr_t     hold_addr,
    input  word_t     hold_wdata,

    // status back to the handler
    output logic      busy,         // selected target not finished
    output logic      unmapped,     // command hits no target
    output word_t     ext_rdata,    // read data of the selected target

    // instruction/data memory
    input  logic      mem_busy,
    input  word_t     mem_rdata,
    output rwi_t      mem_rwi,
    output addr_t     mem_addr,
    output word_t     mem_wdata,

    // external register bank
    input  logic      reg_ack,
    input  word_t     reg_rdata,
    output logic      reg_ri,
    output reg_addr_t reg_addr,

    // spi tft write port
    input  logic      tft_ack,
    output logic      tft_wi,
    output addr_t     tft_addr,
    output word_t     tft_wdata
);

    logic   is_read;    // held command is a load
    logic   is_write;   // held command is a store

    assign is_read  = (hold_rwi == RWI_READ);
    assign is_write = (hold_rwi == RWI_WRITE);

    always_comb begin
        busy      = 1'b0;       // nothing selected, nothing to wait for
        unmapped  = 1'b0;
        ext_rdata = '0;         // zero unless a read target answers
        mem_rwi   = RWI_IDLE;   // memory idle
        mem_addr  = '0;
        mem_wdata = '0;
        reg_ri    = 1'b0;       // register bank idle
        reg_addr  = '0;
        tft_wi    = 1'b0;       // tft idle
        tft_addr  = '0;
        tft_wdata = '0;

        if (hold_rwi != RWI_IDLE) begin
            if (hold_addr <= INSTR_TOP) begin
                // instruction region, always a memory read
                mem_rwi   = RWI_READ;
                mem_addr  = {MEM_TAG, hold_addr[23:0]};
                busy      = mem_busy;
                ext_rdata = mem_rdata;          // returned as the instruction
            end else if (hold_addr <= REG_TOP) begin
                if (is_read) begin
                    reg_ri    = 1'b1;
                    reg_addr  = hold_addr[4:0];     // bank index wraps mod 32
                    busy      = !reg_ack;
                    ext_rdata = reg_rdata;
                end else begin
                    unmapped = 1'b1;            // register region is read only
                end
            end else if (hold_addr <= DATA_TOP) begin
                if (is_read || is_write) begin
                    mem_rwi   = hold_rwi;
                    mem_addr  = {MEM_TAG, hold_addr[23:0]};
                    mem_wdata = hold_wdata;
                    busy      = mem_busy;
                    if (is_read) begin
                        ext_rdata = mem_rdata;
                    end
                end else begin
                    unmapped = 1'b1;            // unknown command code
                end
            end else if (hold_addr < TFT_TOP) begin
                if (is_write) begin
                    tft_wi    = 1'b1;           // held until tft_ack
                    tft_addr  = hold_addr;
                    tft_wdata = hold_wdata;
                    busy      = !tft_ack;
                end else begin
                    unmapped = 1'b1;            // tft port is write only
                end
            end else begin
                unmapped = 1'b1;                // past the end of the map
            end
        end
    end

endmodule

`default_nettype wire

/* hw/t07_mem_handler.sv */
`timescale 1ns/1ns
`default_nettype none

module t07_mem_handler
    import t07_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    // cpu side
    input  logic  cpu_req,          // one-cycle strobe, taken in IDLE only
    input  rwi_t  cpu_rwi,
    input  addr_t cpu_addr,
    input  word_t cpu_wdata,
    output logic  cpu_ready,        // high while a request can be taken
    output logic  cpu_done,         // one-cycle pulse, results valid with it
    output logic  cpu_unmapped,     // access hit no target
    output logic  cpu_instr_fetch,  // access fell in the instruction region
    output word_t cpu_rdata,        // load data or fetched instruction

    // decoder side
    input  logic  busy,             // selected target still working
    input  word_t ext_rdata,        // data from selected target
    input  logic  unmapped,         // held command hits no target
    output rwi_t  hold_rwi,         // RWI_IDLE when nothing is held
    output addr_t hold_addr,
    output word_t hold_wdata
);

    handler_state_t state;
    logic           take_req;       // request accepted this cycle
    logic           retire;         // target finished this cycle

    assign take_req = (state == IDLE) && cpu_req;
    assign retire   = (state == HOLD) && !busy;

    // control path
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= IDLE;
            hold_rwi     <= RWI_IDLE;
            cpu_unmapped <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (take_req) begin
                        state    <= HOLD;
                        hold_rwi <= cpu_rwi;    // command held until target is done
                    end
                end
                HOLD: begin
                    if (retire) begin
                        state        <= DONE;
                        hold_rwi     <= RWI_IDLE;   // drop all target strobes
                        cpu_unmapped <= unmapped;
                    end
                end
                DONE: begin
                    state <= IDLE;              // done pulse lasts one cycle
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // payload of the held request and its result
    always_ff @(posedge clk) begin
        if (take_req) begin
            hold_addr  <= cpu_addr;
            hold_wdata <= cpu_wdata;
        end
        if (retire) begin
            cpu_rdata <= ext_rdata;             // zero for writes and unmapped
        end
    end

    assign cpu_ready = (state == IDLE);
    assign cpu_done  = (state == DONE);

    // hold_addr stays put through DONE, so the region is still visible here
    assign cpu_instr_fetch = (state == DONE) && (hold_addr <= INSTR_TOP);

endmodule

`default_nettype wire

/* hw/t07_pkg.sv */
`default_nettype none

package t07_pkg;

    // plain vectors with a meaning of their own
    typedef logic [31:0] word_t;        // one data word
    typedef logic [31:0] addr_t;        // cpu byte address
    typedef logic [4:0]  reg_addr_t;    // index into external register bank
    typedef logic [7:0]  mem_index_t;   // memory word index, byte addr bits 9:2

    // command code, same encoding on the cpu side and towards memory
    typedef logic [1:0] rwi_t;

    localparam rwi_t RWI_WRITE = 2'b01; // store
    localparam rwi_t RWI_READ  = 2'b10; // load or instruction fetch
    localparam rwi_t RWI_IDLE  = 2'b11; // nothing pending

    // address map
    // 0    .. 1024  instruction fetch from memory
    // 1025 .. 1056  external registers, read only
    // 1057 .. 1792  data memory
    // 1793 .. 2047  tft write port, write only
    localparam addr_t INSTR_TOP = 32'd1024;     // last instruction address
    localparam addr_t REG_TOP   = 32'd1056;     // last register address
    localparam addr_t DATA_TOP  = 32'd1792;     // last data address
    localparam addr_t TFT_TOP   = 32'd2048;     // first address past the tft window

    localparam logic [7:0] MEM_TAG = 8'h33;     // top byte of every memory address

    // memory timing
    localparam int MEM_WAIT = 3;                // cycles the memory holds busy

    typedef logic [$clog2(MEM_WAIT + 1) - 1:0] wait_cnt_t;  // wait counter, counts to MEM_WAIT

    // request handler states
    typedef enum logic [1:0] {
        IDLE,   // ready for a new cpu request
        HOLD,   // request held, target working
        DONE    // one cycle of done pulse with results
    } handler_state_t;

endpackage

`default_nettype wire
